// ==== hw/core_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_ctrl (
   input  logic                clk,
   input  logic                rst,
   output mips_pkg::wb_m2s_t   wb_o,
   input  mips_pkg::wb_s2m_t   wb_i,
   input  mips_pkg::word_t     pc_i,
   input  mips_pkg::word_t     pc_plus4_i,
   input  mips_pkg::word_t     alu_result_i,
   input  mips_pkg::word_t     store_dat_i,
   input  mips_pkg::byte_sel_t store_sel_i,
   input  mips_pkg::word_t     load_dat_i,
   output mips_pkg::decode_t   dec_o,
   output mips_pkg::word_t     instr_o,
   output logic                pc_load_o,
   output logic                rd_we_o,
   output mips_pkg::reg_idx_t  rd_idx_o,
   output mips_pkg::word_t     rd_dat_o,
   output mips_pkg::word_t     load_word_o,
   output logic                halted_o
);

   mips_pkg::ctrl_state_e state;
   logic                  cyc_q;         // Bus cycle open
   logic                  we_q;
   mips_pkg::wb_adr_t     adr_q;
   mips_pkg::byte_sel_t   sel_q;
   mips_pkg::word_t       dat_q;
   mips_pkg::word_t       instr_q;
   mips_pkg::word_t       load_word_q;
   mips_pkg::decode_t     dec;
   logic                  syscall;
   logic                  mem_op;
   logic                  bus_done;      // Ack seen on open cycle
   mips_pkg::opcode_t     op;
   mips_pkg::funct_t      fn;

   assign op       = instr_q[31:26];
   assign fn       = instr_q[5:0];
   assign mem_op   = dec.mem_read | dec.mem_write;
   assign bus_done = cyc_q & wb_i.ack;

   // Field decode; unknown codes behave as NOP
   always_comb begin
      dec     = '0;
      syscall = 1'b0;
      case (op)
         mips_pkg::OP_RTYPE: begin
            dec.dest      = instr_q[15:11];   // rd
            dec.reg_write = 1'b1;
            case (fn)
               mips_pkg::FN_ADDU: dec.alu_op = mips_pkg::ADD;
               mips_pkg::FN_SUBU: dec.alu_op = mips_pkg::SUB;
               mips_pkg::FN_AND:  dec.alu_op = mips_pkg::AND;
               mips_pkg::FN_OR:   dec.alu_op = mips_pkg::OR;
               mips_pkg::FN_SLT:  dec.alu_op = mips_pkg::SLT;
               mips_pkg::FN_SLL: begin
                  dec.alu_op  = mips_pkg::SLL;
                  dec.alu_src = mips_pkg::SHAMT;
               end
               mips_pkg::FN_JR: begin
                  dec.reg_write = 1'b0;
                  dec.jump      = 1'b1;
                  dec.jump_reg  = 1'b1;
               end
               mips_pkg::FN_SYSCALL: begin
                  dec.reg_write = 1'b0;
                  syscall       = 1'b1;
               end
               default: dec.reg_write = 1'b0;
            endcase
         end
         mips_pkg::OP_ADDIU, mips_pkg::OP_ORI, mips_pkg::OP_LUI: begin
            dec.dest      = instr_q[20:16];   // rt
            dec.reg_write = 1'b1;
            dec.alu_src   = (op == mips_pkg::OP_ADDIU) ? mips_pkg::SIGN : mips_pkg::ZERO;
            dec.alu_op    = (op == mips_pkg::OP_ADDIU) ? mips_pkg::ADD :
                            (op == mips_pkg::OP_ORI)   ? mips_pkg::OR  : mips_pkg::LUI;
         end
         mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW,
         mips_pkg::OP_LBU, mips_pkg::OP_LHU: begin
            dec.dest       = instr_q[20:16];
            dec.reg_write  = 1'b1;
            dec.mem_read   = 1'b1;
            dec.alu_src    = mips_pkg::SIGN;            // base + offset
            dec.mem_size   = mips_pkg::mem_size_e'(op[1:0]);
            dec.mem_signed = ~op[2];                    // LBU/LHU have bit 2 set
         end
         mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW: begin
            dec.mem_write = 1'b1;
            dec.alu_src   = mips_pkg::SIGN;
            dec.mem_size  = mips_pkg::mem_size_e'(op[1:0]);
         end
         mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
            dec.branch    = 1'b1;
            dec.branch_ne = op[0];
         end
         mips_pkg::OP_J: dec.jump = 1'b1;
         mips_pkg::OP_JAL: begin
            dec.jump      = 1'b1;
            dec.link      = 1'b1;
            dec.reg_write = 1'b1;
            dec.dest      = mips_pkg::REG_RA;
         end
         default: ;
      endcase
   end

   // FSM and bus cycle control
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= mips_pkg::FETCH;
         cyc_q <= 1'b0;
         we_q  <= 1'b0;
      end else begin
         case (state)
            mips_pkg::FETCH: begin
               if (!cyc_q) begin
                  cyc_q <= 1'b1;        // Open fetch at current PC
                  we_q  <= 1'b0;
               end else if (wb_i.ack) begin
                  cyc_q <= 1'b0;
                  state <= mips_pkg::EXEC;
               end
            end
            mips_pkg::EXEC: begin
               if (syscall) begin
                  state <= mips_pkg::HALT;
               end else if (mem_op) begin
                  cyc_q <= 1'b1;        // Data access starts with MEM
                  we_q  <= dec.mem_write;
                  state <= mips_pkg::MEM;
               end else begin
                  state <= mips_pkg::FETCH;
               end
            end
            mips_pkg::MEM: begin
               if (wb_i.ack) begin
                  cyc_q <= 1'b0;
                  we_q  <= 1'b0;
                  state <= dec.mem_write ? mips_pkg::FETCH : mips_pkg::WB;
               end
            end
            mips_pkg::WB:   state <= mips_pkg::FETCH;
            mips_pkg::HALT: state <= mips_pkg::HALT;   // Until reset
            default:        state <= mips_pkg::FETCH;
         endcase
      end
   end

   // Bus payload and latched words
   always_ff @(posedge clk) begin
      if (state == mips_pkg::FETCH && !cyc_q) begin
         adr_q <= pc_i[31:2];
         sel_q <= '1;
         dat_q <= '0;
      end else if (state == mips_pkg::EXEC) begin
         adr_q <= alu_result_i[31:2];
         sel_q <= store_sel_i;
         dat_q <= store_dat_i;
      end
      if (state == mips_pkg::FETCH && bus_done)
         instr_q <= wb_i.dat;
      if (state == mips_pkg::MEM && bus_done && !we_q)
         load_word_q <= wb_i.dat;
   end

   assign wb_o = '{cyc: cyc_q, stb: cyc_q, we: we_q, adr: adr_q, sel: sel_q, dat: dat_q};

   // PC advances after EXEC, a store ack, or WB
   assign pc_load_o = (state == mips_pkg::EXEC && !syscall && !mem_op) ||
                      (state == mips_pkg::MEM && bus_done && dec.mem_write) ||
                      (state == mips_pkg::WB);

   assign rd_we_o  = (state == mips_pkg::EXEC && dec.reg_write && !dec.mem_read) ||
                     (state == mips_pkg::WB);
   assign rd_idx_o = dec.dest;
   assign rd_dat_o = dec.link     ? pc_plus4_i :   // JAL
                     dec.mem_read ? load_dat_i :   // Loads in WB
                     alu_result_i;

   assign dec_o       = dec;
   assign instr_o     = instr_q;
   assign load_word_o = load_word_q;
   assign halted_o    = (state == mips_pkg::HALT);

endmodule

`default_nettype wire

// ==== hw/mem_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_align (
   input  mips_pkg::decode_t   dec_i,
   input  logic [1:0]          addr_lsb_i,
   input  mips_pkg::word_t     rt_dat_i,
   input  mips_pkg::word_t     load_word_i,
   output mips_pkg::word_t     store_dat_o,
   output mips_pkg::byte_sel_t store_sel_o,
   output mips_pkg::word_t     load_dat_o
);

   mips_pkg::word_t lane;      // Load word shifted down to byte 0
   logic [7:0]      ld_byte;
   logic [15:0]     ld_half;

   // Store side, data moved up to its lane
   always_comb begin
      case (dec_i.mem_size)
         mips_pkg::SIZE_BYTE: begin
            store_dat_o = {24'd0, rt_dat_i[7:0]} << {addr_lsb_i, 3'b000};
            store_sel_o = 4'b0001 << addr_lsb_i;
         end
         mips_pkg::SIZE_HALF: begin
            store_dat_o = {16'd0, rt_dat_i[15:0]} << {addr_lsb_i[1], 4'b0000};
            store_sel_o = addr_lsb_i[1] ? 4'b1100 : 4'b0011;
         end
         default: begin                 // Full word
            store_dat_o = rt_dat_i;
            store_sel_o = 4'b1111;
         end
      endcase
   end

   // Load side
   assign lane    = load_word_i >> {addr_lsb_i, 3'b000};
   assign ld_byte = lane[7:0];
   assign ld_half = addr_lsb_i[1] ? load_word_i[31:16] : load_word_i[15:0];

   always_comb begin
      case (dec_i.mem_size)
         mips_pkg::SIZE_BYTE: begin
            if (dec_i.mem_signed)
               load_dat_o = {{24{ld_byte[7]}}, ld_byte};   // LB
            else
               load_dat_o = {24'd0, ld_byte};              // LBU
         end
         mips_pkg::SIZE_HALF: begin
            if (dec_i.mem_signed)
               load_dat_o = {{16{ld_half[15]}}, ld_half};  // LH
            else
               load_dat_o = {16'd0, ld_half};              // LHU
         end
         default: load_dat_o = load_word_i;
      endcase
   end

endmodule

`default_nettype wire

// ==== hw/mips_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
   input  mips_pkg::decode_t dec_i,
   input  mips_pkg::word_t   instr_i,
   input  mips_pkg::word_t   rs_dat_i,
   input  mips_pkg::word_t   rt_dat_i,
   output mips_pkg::word_t   result_o,
   output logic              equal_o
);

   mips_pkg::word_t op_a;
   mips_pkg::word_t op_b;
   mips_pkg::word_t imm_zx;
   mips_pkg::word_t imm_sx;

   assign imm_zx = {16'h0000, instr_i[15:0]};
   assign imm_sx = {{16{instr_i[15]}}, instr_i[15:0]};

   // Operand select
   always_comb begin
      op_a = rs_dat_i;
      op_b = rt_dat_i;
      case (dec_i.alu_src)
         mips_pkg::ZERO:  op_b = imm_zx;
         mips_pkg::SIGN:  op_b = imm_sx;
         mips_pkg::SHAMT: op_a = {27'd0, instr_i[10:6]};   // Shift count in place of rs
         default: ;
      endcase
   end

   always_comb begin
      case (dec_i.alu_op)
         mips_pkg::ADD: result_o = op_a + op_b;
         mips_pkg::SUB: result_o = op_a - op_b;
         mips_pkg::AND: result_o = op_a & op_b;
         mips_pkg::OR:  result_o = op_a | op_b;
         mips_pkg::SLT: result_o = {31'd0, $signed(op_a) < $signed(op_b)};
         mips_pkg::SLL: result_o = op_b << op_a[4:0];
         mips_pkg::LUI: result_o = {op_b[15:0], 16'h0000};
         default:       result_o = '0;
      endcase
   end

   // Branch compare always on registers
   assign equal_o = (rs_dat_i == rt_dat_i);

endmodule

`default_nettype wire

// ==== hw/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
   parameter mips_pkg::word_t RESET_PC = 32'h0000_0000
) (
   input  logic              clk,
   input  logic              rst,
   output mips_pkg::wb_m2s_t wb_o,
   input  mips_pkg::wb_s2m_t wb_i,
   output logic              halted_o
);

   mips_pkg::decode_t   dec;
   mips_pkg::word_t     instr;
   mips_pkg::word_t     pc;
   mips_pkg::word_t     pc_plus4;
   mips_pkg::word_t     alu_result;
   logic                equal;
   mips_pkg::word_t     rs_dat;
   mips_pkg::word_t     rt_dat;
   logic                pc_load;
   logic                rd_we;
   mips_pkg::reg_idx_t  rd_idx;
   mips_pkg::word_t     rd_dat;
   mips_pkg::word_t     store_dat;
   mips_pkg::byte_sel_t store_sel;
   mips_pkg::word_t     load_word;   // Raw bus word of last load
   mips_pkg::word_t     load_dat;    // Aligned and extended

   core_ctrl u_ctrl (
      .clk          (clk),
      .rst          (rst),
      .wb_o         (wb_o),
      .wb_i         (wb_i),
      .pc_i         (pc),
      .pc_plus4_i   (pc_plus4),
      .alu_result_i (alu_result),
      .store_dat_i  (store_dat),
      .store_sel_i  (store_sel),
      .load_dat_i   (load_dat),
      .dec_o        (dec),
      .instr_o      (instr),
      .pc_load_o    (pc_load),
      .rd_we_o      (rd_we),
      .rd_idx_o     (rd_idx),
      .rd_dat_o     (rd_dat),
      .load_word_o  (load_word),
      .halted_o     (halted_o)
   );

   pc_unit #(.RESET_PC(RESET_PC)) u_pc (
      .clk        (clk),
      .rst        (rst),
      .load_i     (pc_load),
      .dec_i      (dec),
      .instr_i    (instr),
      .rs_dat_i   (rs_dat),
      .equal_i    (equal),
      .pc_o       (pc),
      .pc_plus4_o (pc_plus4)
   );

   mips_alu u_alu (
      .dec_i    (dec),
      .instr_i  (instr),
      .rs_dat_i (rs_dat),
      .rt_dat_i (rt_dat),
      .result_o (alu_result),
      .equal_o  (equal)
   );

   mips_regfile u_regs (
      .clk      (clk),
      .rst      (rst),
      .rs_idx_i (instr[25:21]),   // rs field
      .rt_idx_i (instr[20:16]),   // rt field
      .rs_dat_o (rs_dat),
      .rt_dat_o (rt_dat),
      .we_i     (rd_we),
      .rd_idx_i (rd_idx),
      .rd_dat_i (rd_dat)
   );

   mem_align u_align (
      .dec_i       (dec),
      .addr_lsb_i  (alu_result[1:0]),   // Byte offset of effective address
      .rt_dat_i    (rt_dat),
      .load_word_i (load_word),
      .store_dat_o (store_dat),
      .store_sel_o (store_sel),
      .load_dat_o  (load_dat)
   );

endmodule

`default_nettype wire

// ==== hw/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

   // Widths with a meaning
   typedef logic [31:0] word_t;       // Data or byte address
   typedef logic [4:0]  reg_idx_t;    // Register number
   typedef logic [29:0] wb_adr_t;     // Word address on the bus
   typedef logic [3:0]  byte_sel_t;   // One bit per byte lane
   typedef logic [5:0]  opcode_t;     // instr[31:26]
   typedef logic [5:0]  funct_t;      // instr[5:0]

   // Primary opcodes
   localparam opcode_t OP_RTYPE = 6'h00;
   localparam opcode_t OP_J     = 6'h02;
   localparam opcode_t OP_JAL   = 6'h03;
   localparam opcode_t OP_BEQ   = 6'h04;
   localparam opcode_t OP_BNE   = 6'h05;
   localparam opcode_t OP_ADDIU = 6'h09;
   localparam opcode_t OP_ORI   = 6'h0d;
   localparam opcode_t OP_LUI   = 6'h0f;
   localparam opcode_t OP_LB    = 6'h20;
   localparam opcode_t OP_LH    = 6'h21;
   localparam opcode_t OP_LW    = 6'h23;
   localparam opcode_t OP_LBU   = 6'h24;
   localparam opcode_t OP_LHU   = 6'h25;
   localparam opcode_t OP_SB    = 6'h28;
   localparam opcode_t OP_SH    = 6'h29;
   localparam opcode_t OP_SW    = 6'h2b;

   // R-type funct codes
   localparam funct_t FN_SLL     = 6'h00;
   localparam funct_t FN_JR      = 6'h08;
   localparam funct_t FN_SYSCALL = 6'h0c;
   localparam funct_t FN_ADDU    = 6'h21;
   localparam funct_t FN_SUBU    = 6'h23;
   localparam funct_t FN_AND     = 6'h24;
   localparam funct_t FN_OR      = 6'h25;
   localparam funct_t FN_SLT     = 6'h2a;

   localparam reg_idx_t REG_RA = 5'd31;   // Link register

   // Access size, same code as opcode bits [1:0]
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'b00,
      SIZE_HALF = 2'b01,
      SIZE_WORD = 2'b11
   } mem_size_e;

   typedef enum logic [2:0] {ADD, SUB, AND, OR, SLT, SLL, LUI} alu_op_e;

   // Second operand source; SHAMT swaps in the first operand instead
   typedef enum logic [1:0] {REG, ZERO, SIGN, SHAMT} alu_src_e;

   typedef enum logic [2:0] {FETCH, EXEC, MEM, WB, HALT} ctrl_state_e;

   typedef struct packed {
      alu_op_e   alu_op;
      alu_src_e  alu_src;
      logic      reg_write;
      reg_idx_t  dest;        // Already resolved rd, rt or ra
      logic      link;        // Write PC+4
      logic      mem_read;
      logic      mem_write;
      mem_size_e mem_size;
      logic      mem_signed;
      logic      branch;
      logic      branch_ne;   // BNE sense
      logic      jump;
      logic      jump_reg;    // Target from rs
   } decode_t;

   typedef struct packed {
      logic      cyc;
      logic      stb;
      logic      we;
      wb_adr_t   adr;
      byte_sel_t sel;
      word_t     dat;
   } wb_m2s_t;

   typedef struct packed {
      logic  ack;
      word_t dat;
   } wb_s2m_t;

endpackage

`default_nettype wire

// ==== hw/mips_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
   input  logic               clk,
   input  logic               rst,
   input  mips_pkg::reg_idx_t rs_idx_i,
   input  mips_pkg::reg_idx_t rt_idx_i,
   output mips_pkg::word_t    rs_dat_o,
   output mips_pkg::word_t    rt_dat_o,
   input  logic               we_i,
   input  mips_pkg::reg_idx_t rd_idx_i,
   input  mips_pkg::word_t    rd_dat_i
);

   mips_pkg::word_t regs [0:31];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end else if (we_i && rd_idx_i != 5'd0) begin   // r0 stays zero
         regs[rd_idx_i] <= rd_dat_i;
      end
   end

   // Combinational reads
   assign rs_dat_o = regs[rs_idx_i];
   assign rt_dat_o = regs[rt_idx_i];

endmodule

`default_nettype wire

// ==== hw/pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
   parameter mips_pkg::word_t RESET_PC = 32'h0000_0000
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              load_i,
   input  mips_pkg::decode_t dec_i,
   input  mips_pkg::word_t   instr_i,
   input  mips_pkg::word_t   rs_dat_i,
   input  logic              equal_i,
   output mips_pkg::word_t   pc_o,
   output mips_pkg::word_t   pc_plus4_o
);

   mips_pkg::word_t pc_q;
   mips_pkg::word_t pc_plus4;
   mips_pkg::word_t br_target;
   mips_pkg::word_t jmp_target;
   mips_pkg::word_t next_pc;
   logic            take_branch;

   assign pc_plus4    = pc_q + 32'd4;
   assign br_target   = pc_plus4 + {{14{instr_i[15]}}, instr_i[15:0], 2'b00};
   assign jmp_target  = {pc_plus4[31:28], instr_i[25:0], 2'b00};   // Region of PC+4
   assign take_branch = dec_i.branch & (equal_i ^ dec_i.branch_ne);

   assign next_pc = dec_i.jump_reg ? rs_dat_i   :   // JR
                    dec_i.jump     ? jmp_target :
                    take_branch    ? br_target  :
                    pc_plus4;

   always_ff @(posedge clk) begin
      if (rst)
         pc_q <= RESET_PC;
      else if (load_i)
         pc_q <= next_pc;
   end

   assign pc_o       = pc_q;
   assign pc_plus4_o = pc_plus4;

endmodule

`default_nettype wire

// ==== mips_core.f ====
hw/mips_pkg.sv
hw/mips_alu.sv
hw/mips_regfile.sv
hw/mem_align.sv
hw/pc_unit.sv
hw/core_ctrl.sv
hw/mips_core.sv
verification/mips_core_sva.sv
verification/tb_mips_core.sv

// ==== verification/mips_core_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core_sva (
   input logic              clk,
   input logic              rst,
   input mips_pkg::wb_m2s_t wb_o,
   input mips_pkg::wb_s2m_t wb_i,
   input logic              halted_o
);

   int unsigned sva_errors = 0;
   logic        rst_seen = 1'b0;   // A reset edge has passed

   always @(posedge clk)
      if (rst)
         rst_seen <= 1'b1;

   // Outputs quiet once a reset edge has been taken
   reset_quiet: assert property (@(posedge clk)
      rst_seen && $past(rst) |-> !wb_o.cyc && !wb_o.stb && !halted_o)
      else begin
         sva_errors++;
         $error("cyc, stb or halted_o high during reset");
      end

   stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_o.stb |-> wb_o.cyc)
      else begin
         sva_errors++;
         $error("stb high without cyc");
      end

   // Request held until ack
   req_stable: assert property (@(posedge clk) disable iff (rst)
      wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr) && $stable(wb_o.we) &&
                                $stable(wb_o.sel) && $stable(wb_o.dat))
      else begin
         sva_errors++;
         $error("bus request changed before ack");
      end

   halt_idle: assert property (@(posedge clk) disable iff (rst) halted_o |-> !wb_o.cyc)
      else begin
         sva_errors++;
         $error("bus cycle while halted");
      end

   halt_sticky: assert property (@(posedge clk) disable iff (rst) halted_o |=> halted_o)
      else begin
         sva_errors++;
         $error("halted_o fell without reset");
      end

endmodule

bind mips_core mips_core_sva u_sva (
   .clk      (clk),
   .rst      (rst),
   .wb_o     (wb_o),
   .wb_i     (wb_i),
   .halted_o (halted_o)
);

`default_nettype wire

// ==== verification/tb_mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

   localparam int N_PROG     = 64;                           // Program slots incl. subroutine
   localparam int TIMEOUT_NS = N_PROG * 4 * 5 * 10 + 2000;   // 4 bus phases, 5 cycles each
   localparam int N_TESTS    = 5;

   logic              clk;
   logic              rst = 1'b1;
   mips_pkg::wb_m2s_t bus_req;
   mips_pkg::wb_s2m_t bus_rsp = '0;
   logic              halted;

   logic [31:0] mem [0:255];          // 1 KB, word addressed
   logic [1:0]  wait_tbl [0:255];     // Wait states per bus cycle
   logic        pending = 1'b0;       // Cycle seen, ack not yet given
   int          wait_cnt = 0;
   int          bus_count = 0;

   logic [31:0] exp_adr [$];          // Expected store table
   logic [3:0]  exp_sel [$];
   logic [31:0] exp_dat [$];
   int          exp_test [$];
   int          exp_idx = 0;
   int          errors = 0;
   int          test_checks [N_TESTS];
   int          test_errs [N_TESTS];
   string       test_names [N_TESTS] = '{"alu", "subword_store", "loads", "branch_jump", "halt"};
   int          total_checks;

   mips_core #(.RESET_PC(32'h0000_0000)) u_dut (
      .clk      (clk),
      .rst      (rst),
      .wb_o     (bus_req),
      .wb_i     (bus_rsp),
      .halted_o (halted)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Instruction formats
   function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sa,
                                          input logic [5:0] fn);
      return {6'h00, rs, rt, rd, sa, fn};
   endfunction

   function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] j_type(input logic [5:0] op, input logic [25:0] target);
      return {op, target};
   endfunction

   function automatic logic [31:0] lane_mask(input logic [3:0] sel);
      return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
   endfunction

   task automatic expect_store(input int t, input logic [31:0] adr, input logic [3:0] sel,
                               input logic [31:0] dat);
      exp_test.push_back(t);
      exp_adr.push_back(adr);
      exp_sel.push_back(sel);
      exp_dat.push_back(dat);
   endtask

   task automatic load_program();
      for (int i = 0; i < 256; i++)
         mem[i] = 32'hfc00_0000 | i;                 // Opcode 0x3f, unused
      mem[0]  = i_type(6'h09, 0, 1, 16'd7);          // addiu r1, r0, 7
      mem[1]  = i_type(6'h09, 0, 2, 16'hfffd);       // addiu r2, r0, -3
      mem[2]  = i_type(6'h09, 0, 20, 16'h0200);      // Store area base
      mem[3]  = r_type(1, 2, 3, 0, 6'h21);           // addu r3, r1, r2
      mem[4]  = i_type(6'h2b, 20, 3, 16'd0);         // sw r3, 0(r20)
      mem[5]  = r_type(1, 2, 4, 0, 6'h23);           // subu r4, r1, r2
      mem[6]  = i_type(6'h2b, 20, 4, 16'd4);
      mem[7]  = i_type(6'h0f, 0, 5, 16'h1234);       // lui r5
      mem[8]  = i_type(6'h0d, 5, 5, 16'hf0f0);       // ori r5, r5
      mem[9]  = i_type(6'h2b, 20, 5, 16'd8);
      mem[10] = i_type(6'h0d, 0, 7, 16'hff0f);
      mem[11] = r_type(5, 7, 6, 0, 6'h24);           // and
      mem[12] = i_type(6'h2b, 20, 6, 16'd12);
      mem[13] = r_type(5, 7, 8, 0, 6'h25);           // or
      mem[14] = i_type(6'h2b, 20, 8, 16'd16);
      mem[15] = r_type(2, 1, 9, 0, 6'h2a);           // slt r9, r2, r1
      mem[16] = i_type(6'h2b, 20, 9, 16'd20);
      mem[17] = r_type(1, 2, 10, 0, 6'h2a);          // slt r10, r1, r2
      mem[18] = i_type(6'h2b, 20, 10, 16'd24);
      mem[19] = r_type(0, 1, 11, 4, 6'h00);          // sll r11, r1, 4
      mem[20] = i_type(6'h2b, 20, 11, 16'd28);
      mem[21] = i_type(6'h09, 2, 12, 16'd100);       // addiu r12, r2, 100
      mem[22] = i_type(6'h2b, 20, 12, 16'd32);
      mem[23] = i_type(6'h28, 20, 5, 16'd36);        // sb, offsets 0 to 3
      mem[24] = i_type(6'h28, 20, 5, 16'd41);
      mem[25] = i_type(6'h28, 20, 5, 16'd46);
      mem[26] = i_type(6'h28, 20, 5, 16'd51);
      mem[27] = i_type(6'h29, 20, 5, 16'd52);        // sh, offsets 0 and 2
      mem[28] = i_type(6'h29, 20, 5, 16'd58);
      mem[29] = i_type(6'h09, 0, 21, 16'h0300);      // Load data base
      mem[30] = i_type(6'h20, 21, 14, 16'd0);        // lb
      mem[31] = i_type(6'h2b, 20, 14, 16'd60);
      mem[32] = i_type(6'h24, 21, 15, 16'd1);        // lbu
      mem[33] = i_type(6'h2b, 20, 15, 16'd64);
      mem[34] = i_type(6'h21, 21, 16, 16'd2);        // lh
      mem[35] = i_type(6'h2b, 20, 16, 16'd68);
      mem[36] = i_type(6'h25, 21, 17, 16'd0);        // lhu
      mem[37] = i_type(6'h2b, 20, 17, 16'd72);
      mem[38] = i_type(6'h23, 21, 18, 16'd0);        // lw
      mem[39] = i_type(6'h2b, 20, 18, 16'd76);
      mem[40] = i_type(6'h04, 1, 1, 16'd1);          // beq taken
      mem[41] = i_type(6'h2b, 20, 0, 16'd128);       // Wrong path
      mem[42] = i_type(6'h2b, 20, 1, 16'd80);
      mem[43] = i_type(6'h04, 1, 2, 16'd1);          // beq not taken
      mem[44] = i_type(6'h2b, 20, 2, 16'd84);
      mem[45] = i_type(6'h05, 1, 2, 16'd1);          // bne taken
      mem[46] = i_type(6'h2b, 20, 0, 16'd132);       // Wrong path
      mem[47] = i_type(6'h2b, 20, 3, 16'd88);
      mem[48] = i_type(6'h05, 1, 1, 16'd1);          // bne not taken
      mem[49] = i_type(6'h2b, 20, 4, 16'd92);
      mem[50] = j_type(6'h02, 26'd52);               // j over next
      mem[51] = i_type(6'h2b, 20, 0, 16'd136);
      mem[52] = j_type(6'h03, 26'd60);               // jal subroutine
      mem[53] = i_type(6'h2b, 20, 31, 16'd96);       // Link value
      mem[54] = i_type(6'h2b, 20, 22, 16'd100);      // Set by subroutine
      mem[55] = r_type(0, 0, 0, 0, 6'h0c);           // syscall
      mem[56] = i_type(6'h2b, 20, 0, 16'd140);       // Never after halt
      mem[60] = i_type(6'h0d, 0, 22, 16'h005a);
      mem[61] = r_type(31, 0, 0, 0, 6'h08);          // jr r31
      mem[62] = i_type(6'h2b, 20, 0, 16'd144);       // No delay slot
      mem[192] = 32'h80f7_9a85;                      // Load data at 0x300
   endtask

   task automatic build_expected();
      expect_store(0, 32'h200, 4'hf, 32'd7 + 32'hffff_fffd);
      expect_store(0, 32'h204, 4'hf, 32'd7 - 32'hffff_fffd);
      expect_store(0, 32'h208, 4'hf, {16'h1234, 16'h0000} | 32'h0000_f0f0);
      expect_store(0, 32'h20c, 4'hf, 32'h1234_f0f0 & 32'h0000_ff0f);
      expect_store(0, 32'h210, 4'hf, 32'h1234_f0f0 | 32'h0000_ff0f);
      expect_store(0, 32'h214, 4'hf, 32'd1);         // -3 < 7
      expect_store(0, 32'h218, 4'hf, 32'd0);
      expect_store(0, 32'h21c, 4'hf, 32'd7 << 4);
      expect_store(0, 32'h220, 4'hf, 32'hffff_fffd + 32'd100);
      expect_store(1, 32'h224, 4'b0001, 32'h0000_00f0);
      expect_store(1, 32'h228, 4'b0010, 32'h0000_f000);
      expect_store(1, 32'h22c, 4'b0100, 32'h00f0_0000);
      expect_store(1, 32'h230, 4'b1000, 32'hf000_0000);
      expect_store(1, 32'h234, 4'b0011, 32'h0000_f0f0);
      expect_store(1, 32'h238, 4'b1100, 32'hf0f0_0000);
      expect_store(2, 32'h23c, 4'hf, 32'hffff_ff85);  // Byte 0x85 sign-extended
      expect_store(2, 32'h240, 4'hf, 32'h0000_009a);
      expect_store(2, 32'h244, 4'hf, 32'hffff_80f7);
      expect_store(2, 32'h248, 4'hf, 32'h0000_9a85);
      expect_store(2, 32'h24c, 4'hf, 32'h80f7_9a85);
      expect_store(3, 32'h250, 4'hf, 32'd7);
      expect_store(3, 32'h254, 4'hf, 32'hffff_fffd);
      expect_store(3, 32'h258, 4'hf, 32'd4);
      expect_store(3, 32'h25c, 4'hf, 32'd10);
      expect_store(3, 32'h260, 4'hf, 32'd52 * 4 + 4);  // jal address + 4
      expect_store(3, 32'h264, 4'hf, 32'h0000_005a);
   endtask

   task automatic report_test(input int t);
      $display("Test %s done, %0d checks, %0d errors", test_names[t], test_checks[t],
               test_errs[t]);
   endtask

   task automatic check_store(input logic [31:0] adr, input logic [3:0] sel,
                              input logic [31:0] dat);
      logic [31:0] mask;
      int          t;
      in_table: assert (exp_idx < exp_adr.size()) else begin
         errors++;
         $display("Store to %h seen after the last expected store", adr);
      end
      if (exp_idx < exp_adr.size()) begin
         t    = exp_test[exp_idx];
         mask = lane_mask(exp_sel[exp_idx]);
         test_checks[t]++;
         store_ok: assert (adr == exp_adr[exp_idx] && sel == exp_sel[exp_idx] &&
                           (dat & mask) == (exp_dat[exp_idx] & mask)) else begin
            errors++;
            test_errs[t]++;
            $display("Error: test %s expected adr %h sel %b dat %h, actual adr %h sel %b dat %h",
                     test_names[t], exp_adr[exp_idx], exp_sel[exp_idx],
                     exp_dat[exp_idx] & mask, adr, sel, dat & mask);
         end
         exp_idx++;
         if (exp_idx == exp_adr.size() || exp_test[exp_idx] != t)
            report_test(t);                          // Last store of this test
      end
   endtask

   // Wishbone slave with random wait states
   always @(posedge clk) begin
      if (rst) begin
         bus_rsp <= '0;
         pending <= 1'b0;
      end else if (bus_rsp.ack) begin
         bus_rsp.ack <= 1'b0;                        // One ack per transfer
      end else if (bus_req.cyc && bus_req.stb) begin
         if (!pending) begin
            pending   <= 1'b1;
            wait_cnt  <= wait_tbl[bus_count[7:0]];
            bus_count <= bus_count + 1;
         end else if (wait_cnt != 0) begin
            wait_cnt <= wait_cnt - 1;
         end else begin
            pending     <= 1'b0;
            bus_rsp.ack <= 1'b1;
            bus_rsp.dat <= mem[bus_req.adr[7:0]];
            if (bus_req.we) begin
               for (int b = 0; b < 4; b++)
                  if (bus_req.sel[b])
                     mem[bus_req.adr[7:0]][8*b +: 8] = bus_req.dat[8*b +: 8];
            end
         end
      end
   end

   // Write completes on the edge the DUT samples ack
   always @(posedge clk) begin
      if (!rst && bus_req.cyc && bus_req.we && bus_rsp.ack)
         check_store({bus_req.adr, 2'b00}, bus_req.sel, bus_req.dat);
   end

   initial begin
      #(TIMEOUT_NS);
      $display("watchdog expired before halt");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      void'($urandom(22));
      for (int i = 0; i < 256; i++)
         wait_tbl[i] = $urandom_range(3, 0);
      for (int t = 0; t < N_TESTS; t++) begin
         test_checks[t] = 0;
         test_errs[t]   = 0;
      end
      load_program();
      build_expected();
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      while (halted !== 1'b1)
         @(posedge clk);
      test_checks[4]++;
      halt_last: assert (exp_idx == exp_adr.size()) else begin
         errors++;
         test_errs[4]++;
         $display("Halt reached after only %0d of %0d expected stores", exp_idx,
                  exp_adr.size());
      end
      repeat (20) begin                              // Halt must hold, bus stays idle
         @(posedge clk);
         test_checks[4]++;
         halt_held: assert (halted === 1'b1 && bus_req.cyc === 1'b0) else begin
            errors++;
            test_errs[4]++;
            $display("halted_o fell or a bus cycle started after halt");
         end
      end
      report_test(4);
      total_checks = 0;
      for (int t = 0; t < N_TESTS; t++)
         total_checks += test_checks[t];
      $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", N_TESTS,
               total_checks, errors, u_dut.u_sva.sva_errors);
      if (errors == 0 && u_dut.u_sva.sva_errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
